/* rtl/cp15Pkg.sv */
package cp15Pkg;

  // ********************
  // Widths
  // ********************

  localparam int DataWidth    = 32;
  localparam int NumRegs      = 16;
  localparam int AddrWidth    = 4;
  localparam int Opcode2Width = 3;
  localparam int CrmWidth     = 4;

  // ********************
  // Register map
  // ********************

  localparam logic [AddrWidth-1:0] RegId       = 4'd0;
  localparam logic [AddrWidth-1:0] RegControl  = 4'd1;
  localparam logic [AddrWidth-1:0] RegCacheOps = 4'd7;
  localparam logic [AddrWidth-1:0] RegTlbOps   = 4'd8;

  // Fixed contents of register 0
  localparam logic [DataWidth-1:0] IdValue = 32'h4107_A921;

  // ********************
  // Maintenance operations
  // ********************

  // Register 7 operations, valid for opcode2 000 and 001
  //   crm 0111  flush I and D
  //   crm 0101  flush I
  //   crm 0110  flush D
  //   crm 1011  clean I and D
  //   crm 1010  clean D
  //   crm 1111  flush and clean everything
  //   crm 1110  flush and clean D
  typedef enum logic [2:0] {
    cacheNone     = 3'd0,
    flushBoth     = 3'd1,
    flushIOnly    = 3'd2,
    flushDOnly    = 3'd3,
    cleanBoth     = 3'd4,
    cleanDOnly    = 3'd5,
    flushCleanAll = 3'd6,
    flushCleanD   = 3'd7
  } cacheOpT;

  // Register 8 operations, same opcode2 rule
  //   crm 0111  flush both TLBs
  //   crm 0101  flush instruction TLB
  //   crm 0110  flush data TLB
  typedef enum logic [1:0] {
    tlbNone       = 2'd0,
    tlbFlushBoth  = 2'd1,
    tlbFlushIOnly = 2'd2,
    tlbFlushDOnly = 2'd3
  } tlbOpT;

endpackage

/* rtl/cp15Bus.sv */
`timescale 1ns/1ps

// Granted access, one cycle wide, from the arbiter to the register
// bank and the maintenance decoder
interface cp15Bus;

  logic                              writeEn;
  logic                              readEn;
  logic [cp15Pkg::AddrWidth-1:0]     addr;
  logic [cp15Pkg::DataWidth-1:0]     writeData;
  logic [cp15Pkg::Opcode2Width-1:0]  opcode2;
  logic [cp15Pkg::CrmWidth-1:0]      crm;

  modport arbiter (
    output writeEn,
    output readEn,
    output addr,
    output writeData,
    output opcode2,
    output crm
  );

  modport regFile (
    input writeEn,
    input readEn,
    input addr,
    input writeData
  );

  modport maint (
    input writeEn,
    input addr,
    input opcode2,
    input crm
  );

endinterface

/* rtl/cp15Arbiter.sv */
`timescale 1ns/1ps

// CPU (MCR/MRC) and MMU request merge
// Enable without writeEn is a read
module cp15Arbiter (
  input  logic                              cpuWriteEn,
  input  logic                              cpuEn,
  input  logic                              mmuWriteEn,
  input  logic                              mmuEn,
  input  logic [cp15Pkg::AddrWidth-1:0]     addr,
  input  logic [cp15Pkg::DataWidth-1:0]     cpuWriteData,
  input  logic [cp15Pkg::DataWidth-1:0]     mmuWriteData,
  input  logic [cp15Pkg::Opcode2Width-1:0]  opcode2,
  input  logic [cp15Pkg::CrmWidth-1:0]      crm,
  output logic                              stallCp,
  cp15Bus.arbiter                           bus
);

  logic cpuWrite;
  logic cpuRead;
  logic mmuWrite;
  logic mmuRead;
  logic conflict;
  logic cpuWriteGrant;
  logic cpuReadGrant;

  // ********************
  // Request classification
  // ********************

  assign cpuWrite = cpuWriteEn;
  assign cpuRead  = cpuEn & ~cpuWriteEn;
  assign mmuWrite = mmuWriteEn;
  assign mmuRead  = mmuEn & ~mmuWriteEn;

  // Two writes or two reads in the same cycle
  assign conflict = (cpuWrite & mmuWrite) | (cpuRead & mmuRead);
  assign stallCp  = conflict;

  // ********************
  // Grants
  // ********************

  // MMU always wins, CPU retries after the stall
  assign cpuWriteGrant = cpuWrite & ~conflict;
  assign cpuReadGrant  = cpuRead & ~conflict;

  assign bus.writeEn = mmuWrite | cpuWriteGrant;
  assign bus.readEn  = mmuRead | cpuReadGrant;

  // Write data follows the owner of the granted write
  always_comb begin
    if (mmuWrite) begin
      bus.writeData = mmuWriteData;
    end else begin
      bus.writeData = cpuWriteData;
    end
  end

  // Single shared address and maintenance fields
  assign bus.addr    = addr;
  assign bus.opcode2 = opcode2;
  assign bus.crm     = crm;

endmodule

/* rtl/cp15RegFile.sv */
`timescale 1ns/1ps

// CP15 register bank
module cp15RegFile (
  input  logic                          clk,
  input  logic                          reset,
  cp15Bus.regFile                       bus,
  output logic [cp15Pkg::DataWidth-1:0] readData,
  output logic [cp15Pkg::DataWidth-1:0] control
);

  // Register 0 has no storage
  logic [cp15Pkg::DataWidth-1:0] regs    [1:cp15Pkg::NumRegs-1];
  logic [cp15Pkg::DataWidth-1:0] regView [0:cp15Pkg::NumRegs-1];

  // ********************
  // Write port
  // ********************

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < cp15Pkg::NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (bus.writeEn) begin
      // Writes to the ID register fall through the loop
      for (int i = 1; i < cp15Pkg::NumRegs; i++) begin
        if (bus.addr == cp15Pkg::AddrWidth'(i)) begin
          regs[i] <= bus.writeData;
        end
      end
    end
  end

  // ********************
  // Read port
  // ********************

  always_comb begin
    for (int i = 0; i < cp15Pkg::NumRegs; i++) begin
      if (i == int'(cp15Pkg::RegId)) begin
        regView[i] = cp15Pkg::IdValue;
      end else begin
        regView[i] = regs[i];
      end
    end
  end

  // Zero when no read is granted
  always_comb begin
    if (bus.readEn) begin
      readData = regView[bus.addr];
    end else begin
      readData = '0;
    end
  end

  // Control register is always visible
  assign control = regs[cp15Pkg::RegControl];

endmodule

/* rtl/cp15MaintDecode.sv */
`timescale 1ns/1ps

// Register 7 and 8 writes to cache and TLB maintenance strobes
module cp15MaintDecode (
  input  logic  clk,
  input  logic  reset,
  cp15Bus.maint bus,
  output logic  flushI,
  output logic  flushD,
  output logic  cleanI,
  output logic  cleanD,
  output logic  tlbFlushI,
  output logic  tlbFlushD
);

  logic             opcode2Ok;
  cp15Pkg::cacheOpT cacheOpNext;
  cp15Pkg::cacheOpT cacheOpQ;
  cp15Pkg::tlbOpT   tlbOpNext;
  cp15Pkg::tlbOpT   tlbOpQ;

  // ********************
  // Operation decode
  // ********************

  // Only opcode2 000 and 001 carry an operation
  assign opcode2Ok = (bus.opcode2 == 3'b000) || (bus.opcode2 == 3'b001);

  always_comb begin
    cacheOpNext = cp15Pkg::cacheNone;
    if (bus.writeEn && opcode2Ok && bus.addr == cp15Pkg::RegCacheOps) begin
      case (bus.crm)
        4'b0111: cacheOpNext = cp15Pkg::flushBoth;
        4'b0101: cacheOpNext = cp15Pkg::flushIOnly;
        4'b0110: cacheOpNext = cp15Pkg::flushDOnly;
        4'b1011: cacheOpNext = cp15Pkg::cleanBoth;
        4'b1010: cacheOpNext = cp15Pkg::cleanDOnly;
        4'b1111: cacheOpNext = cp15Pkg::flushCleanAll;
        4'b1110: cacheOpNext = cp15Pkg::flushCleanD;
        default: cacheOpNext = cp15Pkg::cacheNone;
      endcase
    end
  end

  always_comb begin
    tlbOpNext = cp15Pkg::tlbNone;
    if (bus.writeEn && opcode2Ok && bus.addr == cp15Pkg::RegTlbOps) begin
      case (bus.crm)
        4'b0111: tlbOpNext = cp15Pkg::tlbFlushBoth;
        4'b0101: tlbOpNext = cp15Pkg::tlbFlushIOnly;
        4'b0110: tlbOpNext = cp15Pkg::tlbFlushDOnly;
        default: tlbOpNext = cp15Pkg::tlbNone;
      endcase
    end
  end

  // ********************
  // Pipeline stage
  // ********************

  // One operation per cycle, strobes appear the cycle after the write
  always_ff @(posedge clk) begin
    if (reset) begin
      cacheOpQ <= cp15Pkg::cacheNone;
      tlbOpQ   <= cp15Pkg::tlbNone;
    end else begin
      cacheOpQ <= cacheOpNext;
      tlbOpQ   <= tlbOpNext;
    end
  end

  // ********************
  // Strobes
  // ********************

  always_comb begin
    case (cacheOpQ)
      cp15Pkg::flushBoth:     {flushI, flushD, cleanI, cleanD} = 4'b1100;
      cp15Pkg::flushIOnly:    {flushI, flushD, cleanI, cleanD} = 4'b1000;
      cp15Pkg::flushDOnly:    {flushI, flushD, cleanI, cleanD} = 4'b0100;
      cp15Pkg::cleanBoth:     {flushI, flushD, cleanI, cleanD} = 4'b0011;
      cp15Pkg::cleanDOnly:    {flushI, flushD, cleanI, cleanD} = 4'b0001;
      cp15Pkg::flushCleanAll: {flushI, flushD, cleanI, cleanD} = 4'b1111;
      cp15Pkg::flushCleanD:   {flushI, flushD, cleanI, cleanD} = 4'b0101;
      default:                {flushI, flushD, cleanI, cleanD} = 4'b0000;
    endcase
  end

  always_comb begin
    case (tlbOpQ)
      cp15Pkg::tlbFlushBoth:  {tlbFlushI, tlbFlushD} = 2'b11;
      cp15Pkg::tlbFlushIOnly: {tlbFlushI, tlbFlushD} = 2'b10;
      cp15Pkg::tlbFlushDOnly: {tlbFlushI, tlbFlushD} = 2'b01;
      default:                {tlbFlushI, tlbFlushD} = 2'b00;
    endcase
  end

endmodule

/* rtl/coprocessor15.sv */
`timescale 1ns/1ps

// System control coprocessor top level
// CPU uses writeEn for MCR and en alone for MRC
module coprocessor15 (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cpuWriteEn,
  input  logic                              cpuEn,
  input  logic                              mmuWriteEn,
  input  logic                              mmuEn,
  input  logic [cp15Pkg::AddrWidth-1:0]     addr,
  input  logic [cp15Pkg::DataWidth-1:0]     cpuWriteData,
  input  logic [cp15Pkg::DataWidth-1:0]     mmuWriteData,
  input  logic [cp15Pkg::Opcode2Width-1:0]  opcode2,
  input  logic [cp15Pkg::CrmWidth-1:0]      crm,
  output logic                              stallCp,
  output logic                              flushI,
  output logic                              flushD,
  output logic                              cleanI,
  output logic                              cleanD,
  output logic                              tlbFlushI,
  output logic                              tlbFlushD,
  output logic [cp15Pkg::DataWidth-1:0]     readData,
  output logic [cp15Pkg::DataWidth-1:0]     control
);

  // ********************
  // Granted access
  // ********************

  cp15Bus grantBus ();

  cp15Arbiter arbiter (
    .cpuWriteEn   (cpuWriteEn),
    .cpuEn        (cpuEn),
    .mmuWriteEn   (mmuWriteEn),
    .mmuEn        (mmuEn),
    .addr         (addr),
    .cpuWriteData (cpuWriteData),
    .mmuWriteData (mmuWriteData),
    .opcode2      (opcode2),
    .crm          (crm),
    .stallCp      (stallCp),
    .bus          (grantBus.arbiter)
  );

  // ********************
  // Registers and strobes
  // ********************

  cp15RegFile regBank (
    .clk      (clk),
    .reset    (reset),
    .bus      (grantBus.regFile),
    .readData (readData),
    .control  (control)
  );

  cp15MaintDecode maintDecode (
    .clk       (clk),
    .reset     (reset),
    .bus       (grantBus.maint),
    .flushI    (flushI),
    .flushD    (flushD),
    .cleanI    (cleanI),
    .cleanD    (cleanD),
    .tlbFlushI (tlbFlushI),
    .tlbFlushD (tlbFlushD)
  );

endmodule

/* dv/cp15Tb.sv */
`timescale 1ns/1ps

module cp15Tb;

  // Tests take about 370 cycles
  localparam int TimeoutCycles = 2000;
  localparam int RandomCount   = 200;

  logic                                clk = 1'b0;
  logic                                reset;
  logic                                cpuWriteEn;
  logic                                cpuEn;
  logic                                mmuWriteEn;
  logic                                mmuEn;
  logic [cp15Pkg::AddrWidth-1:0]       addr;
  logic [cp15Pkg::DataWidth-1:0]       cpuWriteData;
  logic [cp15Pkg::DataWidth-1:0]       mmuWriteData;
  logic [cp15Pkg::Opcode2Width-1:0]    opcode2;
  logic [cp15Pkg::CrmWidth-1:0]        crm;
  logic                                stallCp;
  logic                                flushI;
  logic                                flushD;
  logic                                cleanI;
  logic                                cleanD;
  logic                                tlbFlushI;
  logic                                tlbFlushD;
  logic [cp15Pkg::DataWidth-1:0]       readData;
  logic [cp15Pkg::DataWidth-1:0]       control;

  // Reference model state
  logic [cp15Pkg::DataWidth-1:0]       model [0:cp15Pkg::NumRegs-1];
  cp15Pkg::cacheOpT                    pendCache;
  cp15Pkg::tlbOpT                      pendTlb;
  logic [31:0]                         rngState;
  int                                  cycleCount = 0;

  coprocessor15 i_dut (
    .clk          (clk),
    .reset        (reset),
    .cpuWriteEn   (cpuWriteEn),
    .cpuEn        (cpuEn),
    .mmuWriteEn   (mmuWriteEn),
    .mmuEn        (mmuEn),
    .addr         (addr),
    .cpuWriteData (cpuWriteData),
    .mmuWriteData (mmuWriteData),
    .opcode2      (opcode2),
    .crm          (crm),
    .stallCp      (stallCp),
    .flushI       (flushI),
    .flushD       (flushD),
    .cleanI       (cleanI),
    .cleanD       (cleanD),
    .tlbFlushI    (tlbFlushI),
    .tlbFlushD    (tlbFlushD),
    .readData     (readData),
    .control      (control)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      stopWithFailure($sformatf("Timeout: tests still running after %0d cycles",
                                TimeoutCycles));
    end
  end

  // ********************
  // Checking
  // ********************

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic checkWord(input string what, input logic [cp15Pkg::DataWidth-1:0] got,
                           input logic [cp15Pkg::DataWidth-1:0] exp);
    if (got !== exp) begin
      stopWithFailure($sformatf("Fail at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stopWithFailure($sformatf("Fail at time %0t: %s is %b, expected %b",
                                $time, what, got, exp));
    end
  endtask

  // Strobe order is flushI, flushD, cleanI, cleanD
  task automatic checkCacheOp(input cp15Pkg::cacheOpT exp);
    logic [3:0] want;
    case (exp)
      cp15Pkg::flushBoth:     want = 4'b1100;
      cp15Pkg::flushIOnly:    want = 4'b1000;
      cp15Pkg::flushDOnly:    want = 4'b0100;
      cp15Pkg::cleanBoth:     want = 4'b0011;
      cp15Pkg::cleanDOnly:    want = 4'b0001;
      cp15Pkg::flushCleanAll: want = 4'b1111;
      cp15Pkg::flushCleanD:   want = 4'b0101;
      default:                want = 4'b0000;
    endcase
    if ({flushI, flushD, cleanI, cleanD} !== want) begin
      stopWithFailure($sformatf("Fail at time %0t: cache strobes %b, expected %b for %s",
                                $time, {flushI, flushD, cleanI, cleanD}, want, exp.name()));
    end
  endtask

  task automatic checkTlbOp(input cp15Pkg::tlbOpT exp);
    logic [1:0] want;
    case (exp)
      cp15Pkg::tlbFlushBoth:  want = 2'b11;
      cp15Pkg::tlbFlushIOnly: want = 2'b10;
      cp15Pkg::tlbFlushDOnly: want = 2'b01;
      default:                want = 2'b00;
    endcase
    if ({tlbFlushI, tlbFlushD} !== want) begin
      stopWithFailure($sformatf("Fail at time %0t: TLB strobes %b, expected %b for %s",
                                $time, {tlbFlushI, tlbFlushD}, want, exp.name()));
    end
  endtask

  // ********************
  // Model helpers
  // ********************

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // Expected operation of a granted register 7 write
  function automatic cp15Pkg::cacheOpT cacheOpFor(input logic wr, input logic [3:0] a,
                                                  input logic [2:0] op2, input logic [3:0] c);
    cp15Pkg::cacheOpT op;
    op = cp15Pkg::cacheNone;
    if (wr && a == cp15Pkg::RegCacheOps && op2 <= 3'd1) begin
      case (c)
        4'b0111: op = cp15Pkg::flushBoth;
        4'b0101: op = cp15Pkg::flushIOnly;
        4'b0110: op = cp15Pkg::flushDOnly;
        4'b1011: op = cp15Pkg::cleanBoth;
        4'b1010: op = cp15Pkg::cleanDOnly;
        4'b1111: op = cp15Pkg::flushCleanAll;
        4'b1110: op = cp15Pkg::flushCleanD;
        default: op = cp15Pkg::cacheNone;
      endcase
    end
    return op;
  endfunction

  function automatic cp15Pkg::tlbOpT tlbOpFor(input logic wr, input logic [3:0] a,
                                              input logic [2:0] op2, input logic [3:0] c);
    cp15Pkg::tlbOpT op;
    op = cp15Pkg::tlbNone;
    if (wr && a == cp15Pkg::RegTlbOps && op2 <= 3'd1) begin
      case (c)
        4'b0111: op = cp15Pkg::tlbFlushBoth;
        4'b0101: op = cp15Pkg::tlbFlushIOnly;
        4'b0110: op = cp15Pkg::tlbFlushDOnly;
        default: op = cp15Pkg::tlbNone;
      endcase
    end
    return op;
  endfunction

  // ********************
  // Access driver
  // ********************

  // One cycle of traffic checked at the falling edge
  task automatic step(input logic cpuW, input logic cpuE, input logic mmuW, input logic mmuE,
                      input logic [3:0] a, input logic [31:0] cpuD, input logic [31:0] mmuD,
                      input logic [2:0] op2, input logic [3:0] c);
    logic        cpuRd;
    logic        mmuRd;
    logic        clash;
    logic        wrGrant;
    logic [31:0] wrData;
    logic [31:0] expRead;
    @(posedge clk);
    cpuWriteEn   <= cpuW;
    cpuEn        <= cpuE;
    mmuWriteEn   <= mmuW;
    mmuEn        <= mmuE;
    addr         <= a;
    cpuWriteData <= cpuD;
    mmuWriteData <= mmuD;
    opcode2      <= op2;
    crm          <= c;
    @(negedge clk);
    cpuRd   = cpuE & ~cpuW;
    mmuRd   = mmuE & ~mmuW;
    clash   = (cpuW & mmuW) | (cpuRd & mmuRd);
    wrGrant = mmuW | (cpuW & ~clash);
    wrData  = mmuW ? mmuD : cpuD;
    expRead = '0;
    if (mmuRd || (cpuRd && !clash)) begin
      expRead = (a == cp15Pkg::RegId) ? cp15Pkg::IdValue : model[a];
    end
    checkBit("stallCp", stallCp, clash);
    checkWord("readData", readData, expRead);
    checkWord("control", control, model[cp15Pkg::RegControl]);
    // Strobes belong to the previous cycle's write
    checkCacheOp(pendCache);
    checkTlbOp(pendTlb);
    pendCache = cacheOpFor(wrGrant, a, op2, c);
    pendTlb   = tlbOpFor(wrGrant, a, op2, c);
    if (wrGrant && a != cp15Pkg::RegId) begin
      model[a] = wrData;
    end
  endtask

  task automatic idle();
    step(1'b0, 1'b0, 1'b0, 1'b0, 4'd0, 32'd0, 32'd0, 3'd0, 4'd0);
  endtask

  task automatic cpuWrite(input logic [3:0] a, input logic [31:0] d);
    step(1'b1, 1'b1, 1'b0, 1'b0, a, d, 32'd0, 3'd0, 4'd0);
  endtask

  task automatic cpuRead(input logic [3:0] a);
    step(1'b0, 1'b1, 1'b0, 1'b0, a, 32'd0, 32'd0, 3'd0, 4'd0);
  endtask

  task automatic maintWrite(input logic [3:0] a, input logic [2:0] op2, input logic [3:0] c);
    step(1'b1, 1'b1, 1'b0, 1'b0, a, nextRandom(), 32'd0, op2, c);
  endtask

  // ********************
  // Directed tests
  // ********************

  task automatic resetTest();
    for (int i = 0; i < cp15Pkg::NumRegs; i++) begin
      cpuRead(cp15Pkg::AddrWidth'(i));
      checkWord("reset value", readData, (i == 0) ? cp15Pkg::IdValue : 32'd0);
    end
    checkWord("control after reset", control, 32'd0);
    checkCacheOp(cp15Pkg::cacheNone);
    checkTlbOp(cp15Pkg::tlbNone);
  endtask

  task automatic writeReadTest();
    logic [31:0] d;
    for (int i = 1; i < cp15Pkg::NumRegs; i++) begin
      d = nextRandom();
      cpuWrite(cp15Pkg::AddrWidth'(i), d);
      cpuRead(cp15Pkg::AddrWidth'(i));
      checkWord("readback", readData, d);
    end
    cpuWrite(cp15Pkg::RegControl, 32'h0000_5A7D);
    idle();
    checkWord("control output", control, 32'h0000_5A7D);
    // ID register ignores writes
    cpuWrite(cp15Pkg::RegId, 32'hFFFF_FFFF);
    cpuRead(cp15Pkg::RegId);
    checkWord("ID readback", readData, cp15Pkg::IdValue);
  endtask

  task automatic conflictTest();
    step(1'b1, 1'b1, 1'b1, 1'b1, 4'd5, 32'h1111_1111, 32'h2222_2222, 3'd0, 4'd0);
    checkBit("stall on two writes", stallCp, 1'b1);
    cpuRead(4'd5);
    checkWord("MMU data kept", readData, 32'h2222_2222);
    step(1'b0, 1'b1, 1'b0, 1'b1, 4'd5, 32'd0, 32'd0, 3'd0, 4'd0);
    checkBit("stall on two reads", stallCp, 1'b1);
    checkWord("read during stall", readData, 32'h2222_2222);
    // Write on one side, read on the other
    step(1'b1, 1'b1, 1'b0, 1'b1, 4'd6, 32'h3333_3333, 32'd0, 3'd0, 4'd0);
    checkBit("stall on CPU write, MMU read", stallCp, 1'b0);
    step(1'b0, 1'b1, 1'b1, 1'b1, 4'd6, 32'd0, 32'h4444_4444, 3'd0, 4'd0);
    checkBit("stall on MMU write, CPU read", stallCp, 1'b0);
    checkWord("old value on mixed access", readData, 32'h3333_3333);
    cpuRead(4'd6);
    checkWord("MMU write stored", readData, 32'h4444_4444);
  endtask

  task automatic cacheOpsTest();
    maintWrite(cp15Pkg::RegCacheOps, 3'b000, 4'b1111);
    idle();
    checkCacheOp(cp15Pkg::flushCleanAll);
    idle();
    checkCacheOp(cp15Pkg::cacheNone);
    // Every crm for opcode2 000, 001 and 010 back to back
    for (int op2 = 0; op2 < 3; op2++) begin
      for (int c = 0; c < 16; c++) begin
        maintWrite(cp15Pkg::RegCacheOps, 3'(op2), 4'(c));
      end
    end
    idle();
    step(1'b0, 1'b1, 1'b0, 1'b0, cp15Pkg::RegCacheOps, 32'd0, 32'd0, 3'b000, 4'b0111);
    idle();
    checkCacheOp(cp15Pkg::cacheNone);
  endtask

  task automatic tlbOpsTest();
    maintWrite(cp15Pkg::RegTlbOps, 3'b000, 4'b0101);
    maintWrite(cp15Pkg::RegTlbOps, 3'b001, 4'b0110);
    checkTlbOp(cp15Pkg::tlbFlushIOnly);
    idle();
    checkTlbOp(cp15Pkg::tlbFlushDOnly);
    idle();
    checkTlbOp(cp15Pkg::tlbNone);
    for (int op2 = 0; op2 < 3; op2++) begin
      for (int c = 0; c < 16; c++) begin
        maintWrite(cp15Pkg::RegTlbOps, 3'(op2), 4'(c));
      end
    end
    idle();
  endtask

  task automatic randomTest();
    logic [31:0] r;
    for (int n = 0; n < RandomCount; n++) begin
      r = nextRandom();
      step(r[0] & r[1], r[0], r[2] & r[3], r[2], r[7:4], nextRandom(), nextRandom(),
           r[10:8], r[14:11]);
    end
    idle();
  endtask

  initial begin
    reset        = 1'b1;
    cpuWriteEn   = 1'b0;
    cpuEn        = 1'b0;
    mmuWriteEn   = 1'b0;
    mmuEn        = 1'b0;
    addr         = '0;
    cpuWriteData = '0;
    mmuWriteData = '0;
    opcode2      = '0;
    crm          = '0;
    rngState     = 32'hda4641a0;
    pendCache    = cp15Pkg::cacheNone;
    pendTlb      = cp15Pkg::tlbNone;
    for (int i = 0; i < cp15Pkg::NumRegs; i++) begin
      model[i] = '0;
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    resetTest();
    writeReadTest();
    conflictTest();
    cacheOpsTest();
    tlbOpsTest();
    randomTest();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* vlog.f */
rtl/cp15Pkg.sv
rtl/cp15Bus.sv
rtl/cp15Arbiter.sv
rtl/cp15RegFile.sv
rtl/cp15MaintDecode.sv
rtl/coprocessor15.sv
dv/cp15Tb.sv

/* Makefile */
# Verilator flow for the CP15 coprocessor testbench
# Any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= cp15Tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

# Static checks on the whole source list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Compile the testbench and the DUT into one executable
build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Run and decide the result from the printed pass line
sim: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
